// File: source/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and cache geometry
  ////////////////////////////////////////////////////////////
  localparam int XLEN         = 32;
  localparam int L1I_SETS_LOG = 2;
  localparam int L1I_LINE_LOG = 1;
  localparam int L1I_SETS     = 1 << L1I_SETS_LOG;
  localparam int L1I_LINE     = 1 << L1I_LINE_LOG;
  localparam int TAG_W        = XLEN - L1I_SETS_LOG - L1I_LINE_LOG - 2;

  localparam logic [XLEN-1:0] PC_INIT  = 32'h0000_0000;
  localparam logic [XLEN-1:0] BURST_LO = 32'h0000_0100; // Burst window start.
  localparam logic [XLEN-1:0] BURST_HI = 32'h0000_01ff; // Burst window end.

  ////////////////////////////////////////////////////////////
  // RV32 opcodes seen by the fetch stage
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0] araddr;
    logic            arvalid;
    logic            busy;    // Refill in progress.
  } ibus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            rvalid;
  } ibus_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] retire_pc;
    logic            pc_change;
    logic            pc_retire;
  } redirect_t;

  typedef struct packed {
    logic spec;
    logic good;
    logic bad;
  } spec_flags_t;

endpackage

`default_nettype wire

// File: source/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1i_cache
  import ifu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] pc_i,
  input  logic            flush_i,
  input  logic            abort_i,
  output ibus_req_t       req_o,
  input  ibus_rsp_t       rsp_i,
  output logic [XLEN-1:0] inst_o,
  output logic            hit_o
);

  typedef enum logic [2:0] {
    RF_IDLE    = 3'd0,
    RF_REQ_LO  = 3'd1, // Even word requested.
    RF_GAP     = 3'd2, // Single mode, drop arvalid between reads.
    RF_REQ_HI  = 3'd3, // Single mode, odd word requested.
    RF_WAIT_HI = 3'd4  // Burst mode, second beat pending.
  } refill_e;

  refill_e state_q;

  logic [XLEN-1:0]  data_q [L1I_SETS][L1I_LINE];
  logic [TAG_W-1:0] tag_q  [L1I_SETS];
  logic [L1I_SETS-1:0] valid_q;

  logic [TAG_W-1:0]        pc_tag;
  logic [L1I_SETS_LOG-1:0] pc_set;
  logic [L1I_LINE_LOG-1:0] pc_off;
  logic [L1I_LINE_LOG-1:0] req_word;
  logic                    line_hit;
  logic                    in_burst;
  logic                    last_beat;
  logic                    arvalid;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////
  assign pc_tag = pc_i[XLEN-1 -: TAG_W];
  assign pc_set = pc_i[L1I_LINE_LOG+2 +: L1I_SETS_LOG];
  assign pc_off = pc_i[2 +: L1I_LINE_LOG];

  assign line_hit = valid_q[pc_set] & (tag_q[pc_set] == pc_tag);
  assign hit_o    = line_hit & (state_q == RF_IDLE);
  assign in_burst = (pc_i >= BURST_LO) & (pc_i <= BURST_HI);

  // Second word of a line is handed over while it is being written.
  assign last_beat = rsp_i.rvalid & ((state_q == RF_REQ_HI) | (state_q == RF_WAIT_HI));
  assign inst_o = (last_beat & (pc_off == L1I_LINE_LOG'(L1I_LINE - 1))) ?
                  rsp_i.rdata : data_q[pc_set][pc_off];

  ////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (state_q)
      RF_IDLE:   arvalid = ~line_hit & ~abort_i; // Miss starts a refill.
      RF_REQ_LO: arvalid = 1'b1;
      RF_REQ_HI: arvalid = 1'b1;
      default:   arvalid = 1'b0;
    endcase
  end

  assign req_word = L1I_LINE_LOG'(state_q == RF_REQ_HI);

  assign req_o.araddr  = {pc_i[XLEN-1:L1I_LINE_LOG+2], req_word, 2'b00};
  assign req_o.arvalid = arvalid;
  assign req_o.busy    = (state_q != RF_IDLE);

  ////////////////////////////////////////////////////////////
  // Refill FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0; // fence.i drops every line.
      end
      case (state_q)
        RF_IDLE: begin
          if (arvalid) begin
            state_q <= RF_REQ_LO;
          end
        end
        RF_REQ_LO: begin
          if (rsp_i.rvalid) begin
            state_q <= in_burst ? RF_WAIT_HI : RF_GAP;
          end
        end
        RF_GAP: begin
          state_q <= RF_REQ_HI;
        end
        RF_REQ_HI, RF_WAIT_HI: begin
          if (rsp_i.rvalid) begin
            state_q         <= RF_IDLE;
            valid_q[pc_set] <= 1'b1;
          end
        end
        default: begin
          state_q <= RF_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == RF_REQ_LO) && rsp_i.rvalid) begin
      data_q[pc_set][0] <= rsp_i.rdata;
    end
    if (last_beat) begin
      data_q[pc_set][1] <= rsp_i.rdata;
      tag_q[pc_set]     <= pc_tag;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // Burst second beat follows at once, with no request in between.
  a_no_req_in_wait: assert property (
    @(posedge clk) disable iff (rst)
      (state_q == RF_REQ_LO && rsp_i.rvalid && in_burst) |=>
        (rsp_i.rvalid && !req_o.arvalid)
  );

  a_legal_state: assert property (
    @(posedge clk) disable iff (rst)
      state_q inside {RF_IDLE, RF_REQ_LO, RF_GAP, RF_REQ_HI, RF_WAIT_HI}
  );

endmodule

`default_nettype wire

// File: source/fetch_seq.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_seq
  import ifu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] inst_i,
  input  logic            hit_i,
  input  logic            busy_i,
  input  redirect_t       redir_i,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  output logic [XLEN-1:0] pc_o,
  output logic            valid_o,
  output logic            ready_o,
  output logic            flush_o,
  output logic            abort_o,
  output spec_flags_t     spec_o
);

  logic [XLEN-1:0] pc_q;
  logic            stall_q;   // Waiting on the backend.
  logic [XLEN-1:0] btb_q;
  logic            btb_v_q;
  logic            spec_q;
  logic [XLEN-1:0] spec_pc_q; // Target that was guessed.
  logic [XLEN-1:0] fall_pc_q;
  logic            spec_br_q; // Guess was for a conditional branch.
  logic            good_q;
  logic            bad_q;
  logic [XLEN-1:0] bad_pc_q;

  logic [6:0]      opcode;
  logic            is_load;
  logic            is_ctrl;
  logic            change;
  logic            retire;
  logic            resolve;
  logic            spec_hit;
  logic            spec_miss;
  logic            bad;
  logic            accept;
  logic            take_btb;
  logic            bad_done;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] miss_pc;

  ////////////////////////////////////////////////////////////
  // Decode and resolution
  ////////////////////////////////////////////////////////////
  assign opcode  = inst_i[6:0];
  assign is_load = (opcode == OP_LOAD);
  assign is_ctrl = (opcode == OP_JAL) | (opcode == OP_JALR) |
                   (opcode == OP_BRANCH) | (opcode == OP_SYSTEM);

  // Backend pulses count only while the backend side is valid.
  assign change  = prev_valid_i & redir_i.pc_change;
  assign retire  = prev_valid_i & redir_i.pc_retire;
  assign resolve = change | retire;

  assign spec_hit = spec_q & ((change & (redir_i.npc == spec_pc_q)) |
                              (retire & (redir_i.retire_pc + 32'd4 == spec_pc_q)));
  assign spec_miss = spec_q & resolve & ~spec_hit;
  assign bad       = bad_q | spec_miss;

  // Not-taken branch retired without a change falls through.
  assign miss_pc = (spec_br_q & ~change) ? fall_pc_q : redir_i.npc;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////
  assign valid_o  = hit_i & ~stall_q & ~bad;
  assign ready_o  = ~valid_o;
  assign accept   = valid_o & next_ready_i;
  assign take_btb = is_ctrl & btb_v_q & ~spec_q;
  assign bad_done = bad_q & next_ready_i & ~busy_i;
  assign pc_seq   = pc_q + 32'd4;

  assign pc_o    = pc_q;
  assign flush_o = accept & (inst_i == INST_FENCE_I);
  assign abort_o = bad;

  assign spec_o.spec = spec_q;
  assign spec_o.good = good_q;
  assign spec_o.bad  = bad;

  ////////////////////////////////////////////////////////////
  // PC and hazard state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      stall_q <= 1'b0;
      btb_v_q <= 1'b0;
      spec_q  <= 1'b0;
      good_q  <= 1'b0;
      bad_q   <= 1'b0;
    end else begin
      good_q <= spec_hit; // One cycle pulse.
      if (change) begin
        btb_v_q <= 1'b1;
      end
      if (spec_hit) begin
        spec_q <= 1'b0;
      end
      if (spec_miss) begin
        spec_q <= 1'b0;
        bad_q  <= 1'b1;
      end
      if (bad_done) begin
        bad_q   <= 1'b0;
        stall_q <= 1'b0;
        pc_q    <= bad_pc_q; // Leave the wrong path.
      end else if (stall_q && resolve && !spec_q && !bad_q && !busy_i) begin
        stall_q <= 1'b0;
        pc_q    <= change ? redir_i.npc : pc_seq;
      end else if (accept) begin
        if (is_load) begin
          stall_q <= 1'b1;
        end else if (is_ctrl) begin
          if (take_btb) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else begin
            stall_q <= 1'b1;
          end
        end else begin
          pc_q <= pc_seq;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (change) begin
      btb_q <= redir_i.npc;
    end
    if (accept && take_btb) begin
      spec_pc_q <= btb_q;
      fall_pc_q <= pc_seq;
      spec_br_q <= (opcode == OP_BRANCH);
    end
    if (spec_miss) begin
      bad_pc_q <= miss_pc;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_good_bad_excl: assert property (
    @(posedge clk) disable iff (rst) !(good_q && bad)
  );

  // A stalling accept raises the stall and empties the output.
  a_stall_holds: assert property (
    @(posedge clk) disable iff (rst)
      (accept && (is_load || (is_ctrl && !take_btb))) |=> (stall_q && !valid_o)
  );

endmodule

`default_nettype wire

// File: source/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top
  import ifu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output ibus_req_t   ibus_req_o,
  input  ibus_rsp_t   ibus_rsp_i,
  input  redirect_t   redir_i,
  input  logic        prev_valid_i,
  input  logic        next_ready_i,
  output fetch_pkt_t  fetch_o,
  output logic        valid_o,
  output logic        ready_o,
  output spec_flags_t spec_o
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] inst;
  logic            hit;
  logic            flush;
  logic            abort;

  l1i_cache l1i_cache_i (
    .clk     (clk),
    .rst     (rst),
    .pc_i    (pc),
    .flush_i (flush),
    .abort_i (abort),
    .req_o   (ibus_req_o),
    .rsp_i   (ibus_rsp_i),
    .inst_o  (inst),
    .hit_o   (hit)
  );

  fetch_seq fetch_seq_i (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst),
    .hit_i        (hit),
    .busy_i       (ibus_req_o.busy), // Refill machine not idle.
    .redir_i      (redir_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .pc_o         (pc),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .flush_o      (flush),
    .abort_o      (abort),
    .spec_o       (spec_o)
  );

  assign fetch_o.inst = inst;
  assign fetch_o.pc   = pc;

endmodule

`default_nettype wire

// File: verif/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module imem_model
  import ifu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  ibus_req_t req_i,
  output ibus_rsp_t rsp_o
);

  localparam int IMEM_LAT = 2;

  logic [XLEN-1:0] rom [128]; // Filled by the testbench.
  int unsigned     req_count;

  logic            busy_q;
  logic [1:0]      wait_q;
  logic [1:0]      beats_q;
  logic [XLEN-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      wait_q    <= 2'd0;
      beats_q   <= 2'd0;
      addr_q    <= '0;
      rsp_o     <= '0;
      req_count <= 0;
    end else begin
      rsp_o.rvalid <= 1'b0;
      if (!busy_q) begin
        if (req_i.arvalid) begin
          busy_q    <= 1'b1;
          wait_q    <= 2'(IMEM_LAT - 1);
          addr_q    <= req_i.araddr;
          beats_q   <= ((req_i.araddr >= BURST_LO) && (req_i.araddr <= BURST_HI)) ?
                       2'd2 : 2'd1;
          req_count <= req_count + 1;
        end
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else if (beats_q != 2'd0) begin
        rsp_o.rvalid <= 1'b1;
        rsp_o.rdata  <= rom[addr_q[8:2]];
        addr_q       <= addr_q + 32'd4; // Burst goes on to the odd word.
        beats_q      <= beats_q - 2'd1;
      end else begin
        busy_q <= 1'b0; // Last beat is taken on this edge.
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ifu
  import ifu_pkg::*;
();

  localparam int N_ROWS      = 19;
  localparam int RST_CYCLES  = 16;
  localparam int CYCLE_LIMIT = N_ROWS * 40 + RST_CYCLES;

  localparam logic [1:0] K_PLAIN = 2'd0;
  localparam logic [1:0] K_JAL   = 2'd1;
  localparam logic [1:0] K_LOAD  = 2'd2;
  localparam logic [1:0] K_FENCE = 2'd3;

  localparam logic [2:0] A_NONE   = 3'd0;
  localparam logic [2:0] A_RETIRE = 3'd1;
  localparam logic [2:0] A_CHANGE = 3'd2;
  localparam logic [2:0] A_GOOD   = 3'd3;
  localparam logic [2:0] A_BAD    = 3'd4;

  localparam logic [1:0] M_NONE = 2'd0;
  localparam logic [1:0] M_SAVE = 2'd1; // Remember the request count.
  localparam logic [1:0] M_SAME = 2'd2;
  localparam logic [1:0] M_MORE = 2'd3;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [1:0]      kind;
    logic [2:0]      act;
    logic [XLEN-1:0] target;
    logic [1:0]      mark;
    logic [2:0]      test;
  } row_t;

  logic        clk;
  logic        rst;
  ibus_req_t   ibus_req;
  ibus_rsp_t   ibus_rsp;
  redirect_t   redir;
  logic        prev_valid;
  logic        next_ready;
  fetch_pkt_t  fetch;
  logic        valid;
  logic        ready;
  spec_flags_t spec;

  row_t            rows [N_ROWS];
  logic [XLEN-1:0] rom [128];
  logic [XLEN-1:0] model_pc;
  logic            model_btb_v;
  logic [XLEN-1:0] acc_pc;
  logic [XLEN-1:0] acc_inst;
  int unsigned     saved_count;
  int              checks;
  int              errors;
  int              cur_test;
  int              test_err [7];
  int              last_row [7];
  int              cycles;

  ifu_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .ibus_req_o   (ibus_req),
    .ibus_rsp_i   (ibus_rsp),
    .redir_i      (redir),
    .prev_valid_i (prev_valid),
    .next_ready_i (next_ready),
    .fetch_o      (fetch),
    .valid_o      (valid),
    .ready_o      (ready),
    .spec_o       (spec)
  );

  imem_model mem_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (ibus_req),
    .rsp_o (ibus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the fetch stage stopped delivering", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "sequential fetch";
      2:       return "cache hits and fence.i";
      3:       return "load stall";
      4:       return "cold branch";
      5:       return "good speculation";
      default: return "bad speculation";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      test_err[cur_test]++;
      $display("ERROR %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic put_row(input int i, input logic [31:0] pc, input logic [1:0] kind,
                         input logic [2:0] act, input logic [31:0] target,
                         input logic [1:0] mark, input logic [2:0] test);
    rows[i] = '{pc, kind, act, target, mark, test};
    last_row[test] = i;
  endtask

  task automatic build_table();
    put_row(0,  32'h000, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(1,  32'h004, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(2,  32'h008, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(3,  32'h00c, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(4,  32'h010, K_JAL,   A_CHANGE, 32'h100, M_NONE, 3'd4);
    put_row(5,  32'h100, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(6,  32'h104, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(7,  32'h108, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(8,  32'h10c, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd1);
    put_row(9,  32'h110, K_JAL,   A_GOOD,   32'h100, M_NONE, 3'd5);
    put_row(10, 32'h100, K_PLAIN, A_NONE,   32'h000, M_SAVE, 3'd2);
    put_row(11, 32'h104, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd2);
    put_row(12, 32'h108, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd2);
    put_row(13, 32'h10c, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd2);
    put_row(14, 32'h110, K_JAL,   A_BAD,    32'h140, M_SAME, 3'd6);
    put_row(15, 32'h140, K_FENCE, A_NONE,   32'h000, M_SAVE, 3'd6);
    put_row(16, 32'h144, K_PLAIN, A_NONE,   32'h000, M_MORE, 3'd2);
    put_row(17, 32'h148, K_LOAD,  A_RETIRE, 32'h000, M_NONE, 3'd3);
    put_row(18, 32'h14c, K_PLAIN, A_NONE,   32'h000, M_NONE, 3'd3);
  endtask

  task automatic build_rom();
    logic [31:0] seed;
    int          k;
    seed = 32'd31311;
    for (k = 0; k < 128; k++) begin
      seed = lcg_next(seed);
      rom[k] = {seed[31:7], 7'b0010011}; // addi with random fields.
    end
    for (k = 0; k < N_ROWS; k++) begin
      case (rows[k].kind)
        K_JAL:   rom[rows[k].pc[8:2]] = {25'h0780000, OP_JAL};
        K_LOAD:  rom[rows[k].pc[8:2]] = {25'h0000041, OP_LOAD};
        K_FENCE: rom[rows[k].pc[8:2]] = INST_FENCE_I;
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Accept one fetch, then play the backend side
  ////////////////////////////////////////////////////////////
  task automatic take_fetch(input int r);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen       = valid;
      next_ready = 1'b1; // Also lets a pending bad redirect finish.
    end
    check_value("pc_o", rows[r].pc, fetch.pc);
    check_value("pc_o model", model_pc, fetch.pc);
    check_value("inst_o", rom[rows[r].pc[8:2]], fetch.inst);
    check_value("ready_o", 32'd0, 32'(ready));
    check_value("busy", 32'd0, 32'(ibus_req.busy)); // A hit needs an idle refill.
    case (rows[r].mark)
      M_SAVE:  saved_count = mem_i.req_count;
      M_SAME:  check_value("req_count", saved_count, mem_i.req_count);
      M_MORE:  check_value("refetch", 32'd1, 32'(mem_i.req_count > saved_count));
      default: ;
    endcase
    acc_pc   = fetch.pc;
    acc_inst = fetch.inst;
    @(negedge clk);
    next_ready = 1'b0;
  endtask

  task automatic backend_step(input int r);
    logic [6:0] opcode;
    logic       is_ctrl;
    opcode  = acc_inst[6:0];
    is_ctrl = (opcode == OP_JAL) || (opcode == OP_JALR) ||
              (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);
    if (is_ctrl) begin
      check_value("spec", 32'(model_btb_v), 32'(spec.spec)); // BTB hit speculates.
    end
    case (rows[r].act)
      A_RETIRE, A_CHANGE: begin
        repeat (3) begin
          check_value("valid_o", 32'd0, 32'(valid));
          check_value("ready_o", 32'd1, 32'(ready));
          @(negedge clk);
        end
        prev_valid      = 1'b1;
        redir.pc_retire = (rows[r].act == A_RETIRE);
        redir.pc_change = (rows[r].act == A_CHANGE);
        redir.npc       = rows[r].target;
        redir.retire_pc = acc_pc;
        @(negedge clk);
        prev_valid = 1'b0;
        redir      = '0;
      end
      A_GOOD, A_BAD: begin
        prev_valid      = 1'b1;
        redir.pc_change = 1'b1;
        redir.npc       = rows[r].target;
        @(negedge clk);
        prev_valid = 1'b0;
        redir      = '0;
        check_value("good", 32'(rows[r].act == A_GOOD), 32'(spec.good));
        check_value("bad", 32'(rows[r].act == A_BAD), 32'(spec.bad));
      end
      default: ;
    endcase
    // Next PC by the sequencer rules.
    if (is_ctrl) begin
      model_pc    = rows[r].target;
      model_btb_v = 1'b1;
    end else begin
      model_pc = acc_pc + 32'd4;
    end
  endtask

  initial begin
    int r;
    int t;
    rst         = 1'b1;
    next_ready  = 1'b0;
    prev_valid  = 1'b0;
    redir       = '0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    cur_test    = 1;
    saved_count = 0;
    model_pc    = PC_INIT;
    model_btb_v = 1'b0;
    for (t = 0; t < 7; t++) begin
      test_err[t] = 0;
      last_row[t] = -1;
    end
    build_table();
    build_rom();
    for (r = 0; r < 128; r++) begin
      mem_i.rom[r] = rom[r];
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;

    for (r = 0; r < N_ROWS; r++) begin
      cur_test = int'(rows[r].test);
      take_fetch(r);
      backend_step(r);
      for (t = 1; t < 7; t++) begin
        if (last_row[t] == r) begin
          $display("test %0d %s: %0d errors", t, test_name(t), test_err[t]);
        end
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/ifu_pkg.sv
source/l1i_cache.sv
source/fetch_seq.sv
source/ifu_top.sv
verif/imem_model.sv
verif/tb_ifu.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_ifu -o sim_ifu \
  > build.log 2>&1 \
  && ./obj_dir/sim_ifu > sim.log 2>&1 \
  || { echo "Build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
